// File: isaPkg.sv
// Instruction set of the 16-bit pipelined core: widths, opcodes and the instruction formats
// Imported by the pipeline stages and used by the testbench to assemble programs
package isaPkg;

   localparam int wordWidth    = 16;
   localparam int regCount     = 8;
   localparam int regAddrWidth = 3;

   // Opcode sits in bits 15:11 of every format
   typedef enum logic [4:0] {
      OP_NOP  = 5'd0,
      OP_HALT = 5'd1,
      OP_ADD  = 5'd2,
      OP_SUB  = 5'd3,
      OP_AND  = 5'd4,
      OP_XOR  = 5'd5,
      OP_ADDI = 5'd6,
      OP_LD   = 5'd7,
      OP_ST   = 5'd8,
      OP_LBI  = 5'd9,
      OP_BEQZ = 5'd10
   } opcode_t;

   // R format: rd = rs op rt, pad bits are zero
   typedef struct packed {
      opcode_t                 opcode;
      logic [regAddrWidth-1:0] rs;
      logic [regAddrWidth-1:0] rt;
      logic [regAddrWidth-1:0] rd;
      logic [1:0]              pad;
   } rFmt_t;

   // I format: ADDI and LD write rt, ST stores rt, all use rs + imm5
   typedef struct packed {
      opcode_t                 opcode;
      logic [regAddrWidth-1:0] rs;
      logic [regAddrWidth-1:0] rt;
      logic [4:0]              imm5;
   } iFmt_t;

   // B format: LBI writes rs, BEQZ tests rs and jumps to pc + 1 + imm8
   typedef struct packed {
      opcode_t                 opcode;
      logic [regAddrWidth-1:0] rs;
      logic [7:0]              imm8;
   } bFmt_t;

   typedef union packed {
      rFmt_t rFmt;
      iFmt_t iFmt;
      bFmt_t bFmt;
   } instr_u;

endpackage

// File: pipePkg.sv
// Pipeline-internal encodings and memory sizes shared by the stages
// The testbench takes the memory depths from here for its program loader
package pipePkg;

   localparam int imemDepth = 256;
   localparam int dmemDepth = 256;
   localparam int pcWidth   = 8;

   // Operation performed by the execute stage
   typedef enum logic [2:0] {
      ALU_ADD   = 3'd0,
      ALU_SUB   = 3'd1,
      ALU_AND   = 3'd2,
      ALU_XOR   = 3'd3,
      ALU_PASSB = 3'd4
   } aluOp_t;

   // Where the committed register value comes from
   typedef enum logic [1:0] {
      WB_ALU  = 2'd0,
      WB_MEM  = 2'd1,
      WB_NONE = 2'd2
   } wbSrc_t;

endpackage

// File: fetch.sv
`timescale 1ns/1ps
// Fetch stage: PC, instruction memory with its load port, and the fetch/decode register
// Freezes on a decode stall or once HALT is seen; a branch redirect wins over both
module fetch (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           imemWrEn,
   input  logic [pipePkg::pcWidth-1:0]    imemWrAddr,
   input  logic [isaPkg::wordWidth-1:0]   imemWrData,
   input  logic                           stall,
   input  logic                           haltSeen,
   input  logic                           redirect,
   input  logic [pipePkg::pcWidth-1:0]    redirectPc,
   output isaPkg::instr_u                 instrD,
   output logic [pipePkg::pcWidth-1:0]    pcD,
   output logic                           validD
);
   import isaPkg::*;
   import pipePkg::*;

   logic [wordWidth-1:0] imem [imemDepth];
   logic [pcWidth-1:0]   pc;

   // Program load port, not touched by reset
   always_ff @(posedge clk) begin
      if (imemWrEn) begin
         imem[imemWrAddr] <= imemWrData;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc     <= '0;
         validD <= 1'b0;
      end else if (redirect) begin
         // Squash the instruction being fetched
         pc     <= redirectPc;
         validD <= 1'b0;
      end else if (stall) begin
         pc     <= pc;
         validD <= validD;
      end else if (haltSeen) begin
         validD <= 1'b0;
      end else begin
         pc     <= pc + 1'b1;
         validD <= 1'b1;
      end
   end

   // Payload follows the PC, held during a stall
   always_ff @(posedge clk) begin
      if (!stall && !redirect && !haltSeen) begin
         instrD <= imem[pc];
         pcD    <= pc;
      end
   end

   // Programs are only loaded while the core is held in reset
   imemLoadInReset: assert property (@(posedge clk) imemWrEn |-> reset)
      else $error("instruction memory written outside reset");

endmodule

// File: decode.sv
`timescale 1ns/1ps
// Decode stage: field decoding, register file with writeback bypass, hazard stall,
// HALT detection, illegal-opcode error and the decode/execute register
module decode (
   input  logic                              clk,
   input  logic                              reset,
   input  isaPkg::instr_u                    instrD,
   input  logic [pipePkg::pcWidth-1:0]       pcD,
   input  logic                              validD,
   input  logic                              redirect,
   input  logic [isaPkg::regAddrWidth-1:0]   exWriteReg,
   input  logic                              exRegWrite,
   input  logic [isaPkg::regAddrWidth-1:0]   memWriteReg,
   input  logic                              memRegWrite,
   input  logic                              wbEn,
   input  logic [isaPkg::regAddrWidth-1:0]   wbReg,
   input  logic [isaPkg::wordWidth-1:0]      wbData,
   output logic                              stall,
   output logic                              haltSeen,
   output logic                              deValid,
   output pipePkg::aluOp_t                   deAluOp,
   output pipePkg::wbSrc_t                   deWbSrc,
   output logic                              deRegWrite,
   output logic [isaPkg::regAddrWidth-1:0]   deWriteReg,
   output logic                              deMemWrite,
   output logic                              deIsBranch,
   output logic                              deIsHalt,
   output logic [isaPkg::wordWidth-1:0]      deOperandA,
   output logic [isaPkg::wordWidth-1:0]      deOperandB,
   output logic [isaPkg::wordWidth-1:0]      deStoreData,
   output logic [pipePkg::pcWidth-1:0]       deBranchTarget,
   output logic                              err
);
   import isaPkg::*;
   import pipePkg::*;

   logic [wordWidth-1:0]    regFile [regCount];
   logic [regAddrWidth-1:0] rs, rt, writeReg;
   logic [wordWidth-1:0]    rsData, rtData, imm5Ext, imm8Ext, operandB;
   logic                    usesRs, usesRt, legal, regWrite, memWrite, isBranch, isHalt;
   logic                    haltLatched;
   aluOp_t                  aluOp;
   wbSrc_t                  wbSrc;

   function automatic logic inFlight(input logic [regAddrWidth-1:0] r);
      return (exRegWrite && exWriteReg == r) || (memRegWrite && memWriteReg == r);
   endfunction

   // rs occupies the same bits in all three views
   assign rs      = instrD.rFmt.rs;
   assign rt      = instrD.iFmt.rt;
   assign imm5Ext = {{(wordWidth-5){instrD.iFmt.imm5[4]}}, instrD.iFmt.imm5};
   assign imm8Ext = {{(wordWidth-8){instrD.bFmt.imm8[7]}}, instrD.bFmt.imm8};

   // A register written this cycle reads back its new value
   assign rsData = (wbEn && wbReg == rs) ? wbData : regFile[rs];
   assign rtData = (wbEn && wbReg == rt) ? wbData : regFile[rt];

   always_ff @(posedge clk) begin
      if (wbEn) begin
         regFile[wbReg] <= wbData;
      end
   end

   always_comb begin
      aluOp    = ALU_ADD;
      wbSrc    = WB_NONE;
      regWrite = 1'b0;
      writeReg = instrD.rFmt.rd;
      memWrite = 1'b0;
      isBranch = 1'b0;
      isHalt   = 1'b0;
      operandB = imm5Ext;
      usesRs   = 1'b0;
      usesRt   = 1'b0;
      legal    = 1'b1;
      case (instrD.rFmt.opcode)
         OP_NOP: ;
         OP_HALT: isHalt = 1'b1;
         OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
            aluOp    = (instrD.rFmt.opcode == OP_SUB) ? ALU_SUB :
                       (instrD.rFmt.opcode == OP_AND) ? ALU_AND :
                       (instrD.rFmt.opcode == OP_XOR) ? ALU_XOR : ALU_ADD;
            wbSrc    = WB_ALU;
            regWrite = 1'b1;
            operandB = rtData;
            usesRs   = 1'b1;
            usesRt   = 1'b1;
         end
         OP_ADDI, OP_LD: begin
            wbSrc    = (instrD.iFmt.opcode == OP_LD) ? WB_MEM : WB_ALU;
            regWrite = 1'b1;
            writeReg = instrD.iFmt.rt;
            usesRs   = 1'b1;
         end
         OP_ST: begin
            memWrite = 1'b1;
            usesRs   = 1'b1;
            usesRt   = 1'b1;
         end
         OP_LBI: begin
            aluOp    = ALU_PASSB;
            wbSrc    = WB_ALU;
            regWrite = 1'b1;
            writeReg = instrD.bFmt.rs;
            operandB = imm8Ext;
         end
         OP_BEQZ: begin
            isBranch = 1'b1;
            usesRs   = 1'b1;
         end
         default: legal = 1'b0;
      endcase
   end

   assign stall    = validD && ((usesRs && inFlight(rs)) || (usesRt && inFlight(rt)));
   assign haltSeen = haltLatched || (validD && isHalt && !redirect);

   always_ff @(posedge clk) begin
      if (reset) begin
         deValid     <= 1'b0;
         haltLatched <= 1'b0;
         err         <= 1'b0;
      end else begin
         // Bubble on stall, squash behind a taken branch
         deValid <= validD && legal && !stall && !redirect;
         if (validD && isHalt && !redirect) begin
            haltLatched <= 1'b1;
         end
         if (validD && !legal && !redirect) begin
            err <= 1'b1;
         end
      end
      deAluOp        <= aluOp;
      deWbSrc        <= wbSrc;
      deRegWrite     <= regWrite;
      deWriteReg     <= writeReg;
      deMemWrite     <= memWrite;
      deIsBranch     <= isBranch;
      deIsHalt       <= isHalt;
      deOperandA     <= rsData;
      deOperandB     <= operandB;
      deStoreData    <= rtData;
      deBranchTarget <= pcD + 1'b1 + instrD.bFmt.imm8;
   end

   // A redirect during a stall still squashes the held instruction
   stallRedirect: assert property (@(posedge clk) disable iff (reset)
      stall && redirect |=> !validD)
      else $error("stalled instruction survived a redirect");

endmodule

// File: execute.sv
`timescale 1ns/1ps
// Execute stage: ALU, BEQZ resolution with redirect, and the execute/memory register
module execute (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              deValid,
   input  pipePkg::aluOp_t                   deAluOp,
   input  pipePkg::wbSrc_t                   deWbSrc,
   input  logic                              deRegWrite,
   input  logic [isaPkg::regAddrWidth-1:0]   deWriteReg,
   input  logic                              deMemWrite,
   input  logic                              deIsBranch,
   input  logic                              deIsHalt,
   input  logic [isaPkg::wordWidth-1:0]      deOperandA,
   input  logic [isaPkg::wordWidth-1:0]      deOperandB,
   input  logic [isaPkg::wordWidth-1:0]      deStoreData,
   input  logic [pipePkg::pcWidth-1:0]       deBranchTarget,
   output logic                              redirect,
   output logic [pipePkg::pcWidth-1:0]       redirectPc,
   output logic [isaPkg::regAddrWidth-1:0]   exWriteReg,
   output logic                              exRegWrite,
   output logic                              emValid,
   output pipePkg::wbSrc_t                   emWbSrc,
   output logic                              emRegWrite,
   output logic [isaPkg::regAddrWidth-1:0]   emWriteReg,
   output logic                              emMemWrite,
   output logic                              emIsHalt,
   output logic [isaPkg::wordWidth-1:0]      emAluResult,
   output logic [isaPkg::wordWidth-1:0]      emStoreData
);
   import isaPkg::*;
   import pipePkg::*;

   logic [wordWidth-1:0] aluResult;

   // LD and ST arrive as ALU_ADD, so the result is their address
   always_comb begin
      case (deAluOp)
         ALU_ADD: aluResult = deOperandA + deOperandB;
         ALU_SUB: aluResult = deOperandA - deOperandB;
         ALU_AND: aluResult = deOperandA & deOperandB;
         ALU_XOR: aluResult = deOperandA ^ deOperandB;
         default: aluResult = deOperandB;
      endcase
   end

   // BEQZ taken when rs is zero
   assign redirect   = deValid && deIsBranch && (deOperandA == '0);
   assign redirectPc = deBranchTarget;

   // Destination still in flight, for the decode hazard check
   assign exWriteReg = deWriteReg;
   assign exRegWrite = deValid && deRegWrite;

   always_ff @(posedge clk) begin
      if (reset) begin
         emValid <= 1'b0;
      end else begin
         emValid <= deValid;
      end
      emWbSrc     <= deWbSrc;
      emRegWrite  <= deRegWrite;
      emWriteReg  <= deWriteReg;
      emMemWrite  <= deMemWrite;
      emIsHalt    <= deIsHalt;
      emAluResult <= aluResult;
      emStoreData <= deStoreData;
   end

   // Both younger instructions are squashed, so a redirect never repeats
   redirectPulse: assert property (@(posedge clk) disable iff (reset) redirect |=> !redirect)
      else $error("redirect held for more than one cycle");

endmodule

// File: memory.sv
`timescale 1ns/1ps
// Memory and writeback: data memory access, writeback source select, commit port, halted flag
module memory (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              emValid,
   input  pipePkg::wbSrc_t                   emWbSrc,
   input  logic                              emRegWrite,
   input  logic [isaPkg::regAddrWidth-1:0]   emWriteReg,
   input  logic                              emMemWrite,
   input  logic                              emIsHalt,
   input  logic [isaPkg::wordWidth-1:0]      emAluResult,
   input  logic [isaPkg::wordWidth-1:0]      emStoreData,
   output logic [isaPkg::regAddrWidth-1:0]   memWriteReg,
   output logic                              memRegWrite,
   output logic                              wbEn,
   output logic [isaPkg::regAddrWidth-1:0]   wbReg,
   output logic [isaPkg::wordWidth-1:0]      wbData,
   output logic                              halted
);
   import isaPkg::*;
   import pipePkg::*;

   logic [wordWidth-1:0]         dmem [dmemDepth];
   logic [$clog2(dmemDepth)-1:0] addr;
   logic [wordWidth-1:0]         readData;

   // Word address from the low bits of base plus offset
   assign addr     = emAluResult[$clog2(dmemDepth)-1:0];
   assign readData = dmem[addr];

   always_ff @(posedge clk) begin
      if (emValid && emMemWrite) begin
         dmem[addr] <= emStoreData;
      end
   end

   assign memWriteReg = emWriteReg;
   assign memRegWrite = emValid && emRegWrite;

   always_ff @(posedge clk) begin
      if (reset) begin
         wbEn   <= 1'b0;
         halted <= 1'b0;
      end else begin
         wbEn <= emValid && emRegWrite && emWbSrc != WB_NONE;
         // Sticky until reset
         if (emValid && emIsHalt) begin
            halted <= 1'b1;
         end
      end
      wbReg  <= emWriteReg;
      wbData <= (emWbSrc == WB_MEM) ? readData : emAluResult;
   end

   // Decode never marks a store as a load result
   noStoreLoad: assert property (@(posedge clk) disable iff (reset)
      emValid |-> !(emMemWrite && emWbSrc == WB_MEM))
      else $error("store with memory writeback source");

endmodule

// File: proc.sv
`timescale 1ns/1ps
// Top level of the five-stage core: connects fetch, decode, execute and memory/writeback
// Programs go in through the load port during reset, results come out on the commit port
module proc (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              imemWrEn,
   input  logic [pipePkg::pcWidth-1:0]       imemWrAddr,
   input  logic [isaPkg::wordWidth-1:0]      imemWrData,
   output logic                              wbEn,
   output logic [isaPkg::regAddrWidth-1:0]   wbReg,
   output logic [isaPkg::wordWidth-1:0]      wbData,
   output logic                              halted,
   output logic                              err
);
   import isaPkg::*;
   import pipePkg::*;

   // Fetch and control back to fetch
   instr_u                  instrD;
   logic [pcWidth-1:0]      pcD, redirectPc, deBranchTarget;
   logic                    validD, stall, haltSeen, redirect;

   // Decode/execute register
   logic                    deValid, deRegWrite, deMemWrite, deIsBranch, deIsHalt;
   aluOp_t                  deAluOp;
   wbSrc_t                  deWbSrc, emWbSrc;
   logic [regAddrWidth-1:0] deWriteReg, exWriteReg, emWriteReg, memWriteReg;
   logic [wordWidth-1:0]    deOperandA, deOperandB, deStoreData;

   // Execute/memory register and hazard reports
   logic                    exRegWrite, memRegWrite;
   logic                    emValid, emRegWrite, emMemWrite, emIsHalt;
   logic [wordWidth-1:0]    emAluResult, emStoreData;
   logic                    decodeErr;

   fetch fetch0 (
      .clk, .reset, .imemWrEn, .imemWrAddr, .imemWrData,
      .stall, .haltSeen, .redirect, .redirectPc,
      .instrD, .pcD, .validD
   );

   decode decode0 (
      .clk, .reset, .instrD, .pcD, .validD, .redirect,
      .exWriteReg, .exRegWrite, .memWriteReg, .memRegWrite,
      .wbEn, .wbReg, .wbData,
      .stall, .haltSeen,
      .deValid, .deAluOp, .deWbSrc, .deRegWrite, .deWriteReg, .deMemWrite,
      .deIsBranch, .deIsHalt, .deOperandA, .deOperandB, .deStoreData, .deBranchTarget,
      .err(decodeErr)
   );

   execute execute0 (
      .clk, .reset,
      .deValid, .deAluOp, .deWbSrc, .deRegWrite, .deWriteReg, .deMemWrite,
      .deIsBranch, .deIsHalt, .deOperandA, .deOperandB, .deStoreData, .deBranchTarget,
      .redirect, .redirectPc, .exWriteReg, .exRegWrite,
      .emValid, .emWbSrc, .emRegWrite, .emWriteReg, .emMemWrite, .emIsHalt,
      .emAluResult, .emStoreData
   );

   memory memory0 (
      .clk, .reset,
      .emValid, .emWbSrc, .emRegWrite, .emWriteReg, .emMemWrite, .emIsHalt,
      .emAluResult, .emStoreData,
      .memWriteReg, .memRegWrite, .wbEn, .wbReg, .wbData, .halted
   );

   // Decode holds the only error source among the stages
   assign err = decodeErr;

endmodule

// File: tbClock.sv
`timescale 1ns/1ps
// Testbench clock with an 8 ns period, and a power-on reset held for the first 8 cycles
module tbClock (
   output logic clk,
   output logic reset
);
   initial begin
      clk   = 1'b0;
      reset = 1'b1;
      repeat (8) @(posedge clk);
      #1 reset = 1'b0;
   end

   always #4 clk = ~clk;
endmodule

// File: procTb.sv
`timescale 1ns/1ps
// Directed tests for the pipelined core: each program is loaded during reset and its commits
// are compared in order with the results of running the program sequentially
module procTb;
   import isaPkg::*;
   import pipePkg::*;

   localparam int numTests = 6;
   localparam int runLimit = 150;

   logic                    clk, porReset, testReset, reset;
   logic                    imemWrEn;
   logic [pcWidth-1:0]      imemWrAddr;
   logic [wordWidth-1:0]    imemWrData;
   logic                    wbEn, halted, err;
   logic [regAddrWidth-1:0] wbReg;
   logic [wordWidth-1:0]    wbData;

   logic [wordWidth-1:0]    prog[$], expData[$], gotData[$];
   logic [regAddrWidth-1:0] expReg[$], gotReg[$];
   logic [wordWidth-1:0]    regModel [regCount];
   logic [wordWidth-1:0]    memModel [dmemDepth];
   logic [31:0]             rngState = 32'd75506;
   int                      errorCount = 0;
   int                      checkCount = 0;

   assign reset = porReset || testReset;

   tbClock clock0 (.clk, .reset(porReset));

   proc dut_i (
      .clk, .reset, .imemWrEn, .imemWrAddr, .imemWrData,
      .wbEn, .wbReg, .wbData, .halted, .err
   );

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      return s ^ (s << 5);
   endfunction

   task automatic randomByte(output logic [7:0] b);
      rngState = xorshift(rngState);
      b = rngState[7:0];
   endtask

   // Instruction assembly through the format views
   function automatic logic [15:0] rInstr(input opcode_t op, input logic [2:0] rd, rs, rt);
      instr_u w;
      w = '0;
      w.rFmt.opcode = op;
      w.rFmt.rs = rs;
      w.rFmt.rt = rt;
      w.rFmt.rd = rd;
      return w;
   endfunction

   function automatic logic [15:0] iInstr(input opcode_t op, input logic [2:0] rt, rs,
                                          input logic [4:0] imm5);
      instr_u w;
      w.iFmt.opcode = op;
      w.iFmt.rs = rs;
      w.iFmt.rt = rt;
      w.iFmt.imm5 = imm5;
      return w;
   endfunction

   function automatic logic [15:0] bInstr(input opcode_t op, input logic [2:0] rs,
                                          input logic [7:0] imm8);
      instr_u w;
      w.bFmt.opcode = op;
      w.bFmt.rs = rs;
      w.bFmt.imm8 = imm8;
      return w;
   endfunction

   task automatic expectCommit(input logic [2:0] r, input logic [15:0] v);
      regModel[r] = v;
      expReg.push_back(r);
      expData.push_back(v);
   endtask

   task automatic loadByte(input logic [2:0] rs, input logic [7:0] imm8);
      prog.push_back(bInstr(OP_LBI, rs, imm8));
      expectCommit(rs, {{8{imm8[7]}}, imm8});
   endtask

   task automatic aluRegs(input opcode_t op, input logic [2:0] rd, rs, rt);
      logic [15:0] a, b, v;
      a = regModel[rs];
      b = regModel[rt];
      case (op)
         OP_SUB:  v = a - b;
         OP_AND:  v = a & b;
         OP_XOR:  v = a ^ b;
         default: v = a + b;
      endcase
      prog.push_back(rInstr(op, rd, rs, rt));
      expectCommit(rd, v);
   endtask

   // ADDI, LD and ST all form rs plus the signed offset
   task automatic baseOffset(input opcode_t op, input logic [2:0] rt, rs, input logic [4:0] imm5);
      logic [15:0] sum;
      sum = regModel[rs] + {{11{imm5[4]}}, imm5};
      prog.push_back(iInstr(op, rt, rs, imm5));
      if (op == OP_ST)
         memModel[sum[7:0]] = regModel[rt];
      else if (op == OP_LD)
         expectCommit(rt, memModel[sum[7:0]]);
      else
         expectCommit(rt, sum);
   endtask

   task automatic runProgram(input string name, input logic expectErr);
      int cycles;
      if (prog.size() > imemDepth) begin
         errorCount++;
         $display("%s: program does not fit in instruction memory", name);
      end
      @(posedge clk);
      #1 testReset = 1'b1;
      foreach (prog[i]) begin
         @(posedge clk);
         #1;
         imemWrEn   = 1'b1;
         imemWrAddr = 8'(i);
         imemWrData = prog[i];
      end
      @(posedge clk);
      #1 imemWrEn = 1'b0;
      @(posedge clk);
      #1 testReset = 1'b0;
      gotReg.delete();
      gotData.delete();
      cycles = 0;
      while (halted !== 1'b1 && cycles < runLimit) begin
         @(negedge clk);
         if (wbEn) begin
            gotReg.push_back(wbReg);
            gotData.push_back(wbData);
         end
         cycles++;
      end
      if (halted !== 1'b1) begin
         errorCount++;
         $display("%s: core did not halt within %0d cycles", name, runLimit);
      end
      // Anything committing here came after HALT
      repeat (6) begin
         @(negedge clk);
         if (wbEn) begin
            gotReg.push_back(wbReg);
            gotData.push_back(wbData);
         end
      end
      if (halted !== 1'b1) begin
         errorCount++;
         $display("%s: halted did not stay high", name);
      end
      if (gotReg.size() != expReg.size()) begin
         errorCount++;
         $display("%s: expected %0d commits but saw %0d", name, expReg.size(), gotReg.size());
      end
      foreach (expReg[i]) begin
         if (i < gotReg.size()) begin
            checkCount += 2;
            if (gotReg[i] !== expReg[i]) begin
               errorCount++;
               $display("ERROR %s commit %0d wbReg: expected 0x%h, got 0x%h",
                        name, i, expReg[i], gotReg[i]);
            end
            if (gotData[i] !== expData[i]) begin
               errorCount++;
               $display("ERROR %s commit %0d wbData: expected 0x%h, got 0x%h",
                        name, i, expData[i], gotData[i]);
            end
         end
      end
      checkCount++;
      if (err !== expectErr) begin
         errorCount++;
         $display("ERROR %s err: expected 0x%h, got 0x%h", name, expectErr, err);
      end
      prog.delete();
      expReg.delete();
      expData.delete();
   endtask

   task automatic aluOps;
      logic [7:0] v;
      for (int r = 1; r <= 6; r++) begin
         randomByte(v);
         loadByte(3'(r), v);
      end
      aluRegs(OP_ADD, 3'd7, 3'd1, 3'd2);
      aluRegs(OP_SUB, 3'd0, 3'd3, 3'd4);
      aluRegs(OP_AND, 3'd1, 3'd5, 3'd6);
      aluRegs(OP_XOR, 3'd2, 3'd7, 3'd0);
      randomByte(v);
      baseOffset(OP_ADDI, 3'd3, 3'd2, v[4:0]);
      randomByte(v);
      baseOffset(OP_ADDI, 3'd4, 3'd1, v[4:0]);
      prog.push_back(bInstr(OP_HALT, 3'd0, 8'd0));
      runProgram("alu", 1'b0);
   endtask

   // Every instruction reads the result just before it
   task automatic hazardChain;
      logic [7:0] v;
      randomByte(v);
      loadByte(3'd1, v);
      baseOffset(OP_ADDI, 3'd2, 3'd1, 5'd7);
      aluRegs(OP_ADD, 3'd3, 3'd2, 3'd1);
      aluRegs(OP_SUB, 3'd4, 3'd3, 3'd2);
      aluRegs(OP_XOR, 3'd5, 3'd4, 3'd3);
      aluRegs(OP_AND, 3'd6, 3'd5, 3'd4);
      baseOffset(OP_ADDI, 3'd6, 3'd6, 5'h1b);
      aluRegs(OP_ADD, 3'd1, 3'd6, 3'd6);
      prog.push_back(bInstr(OP_HALT, 3'd0, 8'd0));
      runProgram("hazard", 1'b0);
   endtask

   task automatic storeLoad;
      logic [7:0] v;
      loadByte(3'd0, 8'd40);
      for (int r = 1; r <= 4; r++) begin
         randomByte(v);
         loadByte(3'(r), v);
      end
      baseOffset(OP_ST, 3'd1, 3'd0, 5'd0);
      baseOffset(OP_ST, 3'd2, 3'd0, 5'd1);
      baseOffset(OP_ST, 3'd3, 3'd0, 5'd9);
      baseOffset(OP_ST, 3'd4, 3'd0, 5'h1d);
      baseOffset(OP_LD, 3'd5, 3'd0, 5'd9);
      baseOffset(OP_LD, 3'd6, 3'd0, 5'h1d);
      baseOffset(OP_LD, 3'd7, 3'd0, 5'd0);
      baseOffset(OP_LD, 3'd1, 3'd0, 5'd1);
      prog.push_back(bInstr(OP_HALT, 3'd0, 8'd0));
      runProgram("store/load", 1'b0);
   endtask

   task automatic branches;
      logic [7:0] v;
      loadByte(3'd1, 8'd0);
      randomByte(v);
      loadByte(3'd2, v | 8'h01);
      // Taken: 2 + 1 + 2 lands on the second branch, both ADDIs skipped
      prog.push_back(bInstr(OP_BEQZ, 3'd1, 8'd2));
      prog.push_back(iInstr(OP_ADDI, 3'd3, 3'd1, 5'd1));
      prog.push_back(iInstr(OP_ADDI, 3'd4, 3'd1, 5'd2));
      // Not taken, r2 is nonzero
      prog.push_back(bInstr(OP_BEQZ, 3'd2, 8'd2));
      baseOffset(OP_ADDI, 3'd5, 3'd2, 5'd3);
      baseOffset(OP_ADDI, 3'd6, 3'd5, 5'h1f);
      prog.push_back(bInstr(OP_HALT, 3'd0, 8'd0));
      runProgram("branch", 1'b0);
   endtask

   task automatic haltStop;
      logic [7:0] v;
      randomByte(v);
      loadByte(3'd1, v);
      baseOffset(OP_ADDI, 3'd2, 3'd1, 5'd1);
      prog.push_back(bInstr(OP_HALT, 3'd0, 8'd0));
      prog.push_back(iInstr(OP_ADDI, 3'd3, 3'd1, 5'd2));
      prog.push_back(bInstr(OP_LBI, 3'd4, 8'd5));
      prog.push_back(rInstr(OP_ADD, 3'd5, 3'd1, 3'd2));
      runProgram("halt", 1'b0);
   endtask

   task automatic illegalOpcode;
      logic [7:0] v;
      randomByte(v);
      loadByte(3'd1, v);
      // Opcode 31 is outside the ISA
      prog.push_back(16'hf800);
      baseOffset(OP_ADDI, 3'd2, 3'd1, 5'd4);
      prog.push_back(bInstr(OP_HALT, 3'd0, 8'd0));
      runProgram("illegal", 1'b1);
   endtask

   initial begin
      testReset  = 1'b1;
      imemWrEn   = 1'b0;
      imemWrAddr = '0;
      imemWrData = '0;
      wait (!porReset);
      aluOps();
      hazardChain();
      storeLoad();
      branches();
      haltStop();
      illegalOpcode();
      $display("%0d errors in %0d checks", errorCount, checkCount);
      if (errorCount == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

   // Budget of 200 cycles per test
   initial begin
      repeat (numTests * 200) @(posedge clk);
      $display("watchdog expired after %0d cycles before the tests finished", numTests * 200);
      $display("%0d errors in %0d checks", errorCount, checkCount);
      $display("=== FAIL ===");
      $finish;
   end
endmodule

// File: filelist.f
isaPkg.sv
pipePkg.sv
fetch.sv
decode.sv
execute.sv
memory.sv
proc.sv
tbClock.sv
procTb.sv

// File: Makefile
# Verilator build and run of the pipelined core testbench
VERILATOR ?= verilator
TOP       ?= procTb
FILELIST  ?= filelist.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= === PASS ===

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)
